// ==== verilog/alu_pkg.sv ====
package alu_pkg;

  // Operation class chosen by the issue stage
  typedef enum logic [2:0] {
    cls_none,
    cls_set_lo,
    cls_set_hi,
    cls_logic,
    cls_arith,
    cls_shift,
    cls_branch
  } op_class_t;

  // Logic and arithmetic codes
  localparam logic [2:0] al_and = 3'd0;
  localparam logic [2:0] al_or  = 3'd1;
  localparam logic [2:0] al_add = 3'd2;
  localparam logic [2:0] al_sub = 3'd3;
  localparam logic [2:0] al_xor = 3'd4;

  // Shift group, flag ops and inc/dec share this code space
  localparam logic [3:0] sh_lsl   = 4'd0;
  localparam logic [3:0] sh_lsr   = 4'd1;
  localparam logic [3:0] sh_lsl8  = 4'd2;
  localparam logic [3:0] sh_lsr8  = 4'd3;
  localparam logic [3:0] sh_asl   = 4'd4;
  localparam logic [3:0] sh_asr   = 4'd5;
  localparam logic [3:0] sh_savef = 4'd6;
  localparam logic [3:0] sh_setf  = 4'd7;
  localparam logic [3:0] sh_clrf  = 4'd8;
  localparam logic [3:0] sh_rstrf = 4'd9;
  localparam logic [3:0] sh_inc   = 4'd10;
  localparam logic [3:0] sh_dec   = 4'd11;

  // Branch condition index in bits 4..1 of the branch code
  localparam logic [3:0] cond_br   = 4'd0;
  localparam logic [3:0] cond_bl   = 4'd1;
  localparam logic [3:0] cond_bge  = 4'd2;
  localparam logic [3:0] cond_ble  = 4'd3;
  localparam logic [3:0] cond_bg   = 4'd4;
  localparam logic [3:0] cond_bule = 4'd5;
  localparam logic [3:0] cond_bug  = 4'd6;
  localparam logic [3:0] cond_bz   = 4'd7;
  localparam logic [3:0] cond_bnz  = 4'd8;
  localparam logic [3:0] cond_bc   = 4'd9;
  localparam logic [3:0] cond_bnc  = 4'd10;
  localparam logic [3:0] cond_bs   = 4'd11;
  localparam logic [3:0] cond_bns  = 4'd12;
  localparam logic [3:0] cond_bv   = 4'd13;
  localparam logic [3:0] cond_bnv  = 4'd14;

  // Flag vector layout
  localparam int flag_sign  = 0;
  localparam int flag_zero  = 1;
  localparam int flag_ovf   = 2;
  localparam int flag_carry = 3;
  localparam int FLAG_W     = 4;

  localparam int IMM_W = 8;

endpackage

// ==== verilog/alu_issue.sv ====
module alu_issue #(
  parameter int DATA_W = 16
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      op_set_val,
  input  logic                      op_set_hi,
  input  logic                      op_al_val,
  input  logic [2:0]                op_al_code,
  input  logic                      op_shift_val,
  input  logic [3:0]                op_shift_code,
  input  logic                      op_branch_val,
  input  logic [4:0]                op_branch_code,
  input  logic [alu_pkg::IMM_W-1:0] v_data,
  input  logic [DATA_W-1:0]         pc,
  input  logic [DATA_W-1:0]         rf_ra,
  input  logic [DATA_W-1:0]         rf_rb,
  output alu_pkg::op_class_t        is_class,
  output logic [4:0]                is_code,
  output logic [DATA_W-1:0]         is_a,
  output logic [DATA_W-1:0]         is_b,
  output logic [DATA_W-1:0]         is_imm,
  output logic [DATA_W-1:0]         is_pc
);

  localparam int EXT_W = DATA_W - alu_pkg::IMM_W;

  alu_pkg::op_class_t cls;
  logic [4:0]         code;
  logic               is_incdec;
  logic [DATA_W-1:0]  b_sel;

  // Decoder guarantees a single strobe, so priority order is arbitrary
  always_comb
  begin
    cls  = alu_pkg::cls_none;
    code = '0;
    if (op_set_val)
    begin
      if (op_set_hi)
        cls = alu_pkg::cls_set_hi;
      else
        cls = alu_pkg::cls_set_lo;
    end
    else if (op_al_val)
    begin
      if (op_al_code == alu_pkg::al_add || op_al_code == alu_pkg::al_sub)
        cls = alu_pkg::cls_arith;
      else
        cls = alu_pkg::cls_logic;
      code = {2'b00, op_al_code};
    end
    else if (op_shift_val)
    begin
      cls  = alu_pkg::cls_shift;
      code = {1'b0, op_shift_code};
    end
    else if (op_branch_val)
    begin
      cls  = alu_pkg::cls_branch;
      code = op_branch_code;
    end
  end

  // inc/dec step is the immediate plus one
  assign is_incdec = op_shift_val &&
                     (op_shift_code == alu_pkg::sh_inc || op_shift_code == alu_pkg::sh_dec);
  assign b_sel = is_incdec ? {{EXT_W{1'b0}}, v_data} + 1'b1 : rf_rb;

  always_ff @(posedge clk)
  begin
    if (!rst)
      is_class <= alu_pkg::cls_none;
    else
      is_class <= cls;
  end

  always_ff @(posedge clk)
  begin
    is_code <= code;
    is_a    <= rf_ra;
    is_b    <= b_sel;
    is_imm  <= {{EXT_W{v_data[alu_pkg::IMM_W-1]}}, v_data};
    is_pc   <= pc;
  end

  a_one_strobe: assert property (@(posedge clk) disable iff (!rst)
    $onehot0({op_set_val, op_al_val, op_shift_val, op_branch_val}));

endmodule

// ==== verilog/alu_execute.sv ====
module alu_execute #(
  parameter int DATA_W = 16
) (
  input  logic                       clk,
  input  logic                       rst,
  input  alu_pkg::op_class_t         is_class,
  input  logic [4:0]                 is_code,
  input  logic [DATA_W-1:0]          is_a,
  input  logic [DATA_W-1:0]          is_b,
  input  logic [DATA_W-1:0]          is_imm,
  input  logic [DATA_W-1:0]          is_pc,
  input  logic [alu_pkg::FLAG_W-1:0] flags_next,
  output logic [DATA_W-1:0]          ex_result,
  output logic                       ex_result_val,
  output logic [alu_pkg::FLAG_W-1:0] ex_flags,
  output logic                       ex_flag_wr,
  output logic                       ex_branch,
  output logic [3:0]                 ex_cond,
  output logic [DATA_W-1:0]          ex_target
);

  localparam int MSB = DATA_W - 1;
  localparam int LO  = DATA_W - alu_pkg::IMM_W;

  logic                       carry_in;
  logic                       sub_op;
  logic [DATA_W-1:0]          b_op;
  logic                       cin_op;
  logic [DATA_W:0]            sum;
  logic [alu_pkg::FLAG_W-1:0] arith_flags;
  logic [DATA_W-1:0]          res;
  logic                       res_val;
  logic [alu_pkg::FLAG_W-1:0] flags;
  logic                       flag_wr;

  // Forwarded flags, so back-to-back ops chain the carry
  assign carry_in = flags_next[alu_pkg::flag_carry];

  // sub and dec add the inverted operand
  assign sub_op = (is_class == alu_pkg::cls_arith && is_code[2:0] == alu_pkg::al_sub) ||
                  (is_class == alu_pkg::cls_shift && is_code[3:0] == alu_pkg::sh_dec);
  assign b_op   = sub_op ? ~is_b : is_b;
  // add/sub take the carry, inc uses 0 and dec uses 1
  assign cin_op = (is_class == alu_pkg::cls_arith) ? carry_in : sub_op;
  assign sum    = {1'b0, is_a} + {1'b0, b_op} + {{DATA_W{1'b0}}, cin_op};

  always_comb
  begin
    arith_flags                      = '0;
    arith_flags[alu_pkg::flag_sign]  = sum[MSB];
    arith_flags[alu_pkg::flag_zero]  = (sum[MSB:0] == '0);
    arith_flags[alu_pkg::flag_ovf]   = (is_a[MSB] == b_op[MSB]) && (sum[MSB] != is_a[MSB]);
    arith_flags[alu_pkg::flag_carry] = sum[DATA_W];
  end

  always_comb
  begin
    res     = '0;
    res_val = 1'b0;
    flags   = flags_next;
    flag_wr = 1'b0;
    case (is_class)
      alu_pkg::cls_set_lo:
      begin
        res     = is_imm;
        res_val = 1'b1;
      end
      alu_pkg::cls_set_hi:
      begin
        res     = {is_imm[alu_pkg::IMM_W-1:0], is_a[LO-1:0]};
        res_val = 1'b1;
      end
      alu_pkg::cls_logic:
      begin
        case (is_code[2:0])
          alu_pkg::al_and: res = is_a & is_b;
          alu_pkg::al_or:  res = is_a | is_b;
          default:         res = is_a ^ is_b;
        endcase
        res_val                   = 1'b1;
        flag_wr                   = 1'b1;
        flags[alu_pkg::flag_sign] = res[MSB];
        flags[alu_pkg::flag_zero] = (res == '0);
      end
      alu_pkg::cls_arith:
      begin
        res     = sum[MSB:0];
        res_val = 1'b1;
        flags   = arith_flags;
        flag_wr = 1'b1;
      end
      alu_pkg::cls_shift:
      begin
        case (is_code[3:0])
          alu_pkg::sh_lsl, alu_pkg::sh_asl:
          begin
            res                        = {is_a[MSB-1:0], carry_in};
            res_val                    = 1'b1;
            flags[alu_pkg::flag_carry] = is_a[MSB];
            flag_wr                    = 1'b1;
          end
          alu_pkg::sh_lsr:
          begin
            res                        = {carry_in, is_a[MSB:1]};
            res_val                    = 1'b1;
            flags[alu_pkg::flag_carry] = is_a[0];
            flag_wr                    = 1'b1;
          end
          alu_pkg::sh_asr:
          begin
            res                        = {is_a[MSB], is_a[MSB:1]};
            res_val                    = 1'b1;
            flags[alu_pkg::flag_carry] = is_a[0];
            flag_wr                    = 1'b1;
          end
          alu_pkg::sh_lsl8:
          begin
            res     = is_a << 8;
            res_val = 1'b1;
          end
          alu_pkg::sh_lsr8:
          begin
            res     = is_a >> 8;
            res_val = 1'b1;
          end
          alu_pkg::sh_savef:
          begin
            res     = {{(DATA_W-alu_pkg::FLAG_W){1'b0}}, flags_next};
            res_val = 1'b1;
          end
          alu_pkg::sh_setf:
          begin
            flags   = flags_next | is_imm[alu_pkg::FLAG_W-1:0];
            flag_wr = 1'b1;
          end
          alu_pkg::sh_clrf:
          begin
            flags   = flags_next & ~is_imm[alu_pkg::FLAG_W-1:0];
            flag_wr = 1'b1;
          end
          alu_pkg::sh_rstrf:
          begin
            flags   = is_a[alu_pkg::FLAG_W-1:0];
            flag_wr = 1'b1;
          end
          alu_pkg::sh_inc, alu_pkg::sh_dec:
          begin
            res     = sum[MSB:0];
            res_val = 1'b1;
            flags   = arith_flags;
            flag_wr = 1'b1;
          end
          default: ;
        endcase
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!rst)
    begin
      ex_result_val <= 1'b0;
      ex_flag_wr    <= 1'b0;
      ex_branch     <= 1'b0;
    end
    else
    begin
      ex_result_val <= res_val;
      ex_flag_wr    <= flag_wr;
      ex_branch     <= (is_class == alu_pkg::cls_branch);
    end
  end

  // Relative form when bit 0 is set
  always_ff @(posedge clk)
  begin
    ex_result <= res;
    ex_flags  <= flags;
    ex_cond   <= is_code[4:1];
    ex_target <= is_code[0] ? is_pc + is_imm : is_a;
  end

  a_result_or_branch: assert property (@(posedge clk) disable iff (!rst)
    !(ex_result_val && ex_branch));

endmodule

// ==== verilog/alu_retire.sv ====
module alu_retire #(
  parameter int DATA_W = 16
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [DATA_W-1:0]          ex_result,
  input  logic                       ex_result_val,
  input  logic [alu_pkg::FLAG_W-1:0] ex_flags,
  input  logic                       ex_flag_wr,
  input  logic                       ex_branch,
  input  logic [3:0]                 ex_cond,
  input  logic [DATA_W-1:0]          ex_target,
  output logic [alu_pkg::FLAG_W-1:0] flags_next,
  output logic [DATA_W-1:0]          result,
  output logic                       result_val,
  output logic                       taken_pc,
  output logic [DATA_W-1:0]          next_pc
);

  logic [alu_pkg::FLAG_W-1:0] flags_q;
  logic                       s;
  logic                       z;
  logic                       v;
  logic                       c;
  logic                       lt;
  logic                       cond_true;

  // Value after this edge goes back to execute
  assign flags_next = ex_flag_wr ? ex_flags : flags_q;

  always_ff @(posedge clk)
  begin
    if (!rst)
      flags_q <= '0;
    else
      flags_q <= flags_next;
  end

  assign s  = flags_q[alu_pkg::flag_sign];
  assign z  = flags_q[alu_pkg::flag_zero];
  assign v  = flags_q[alu_pkg::flag_ovf];
  assign c  = flags_q[alu_pkg::flag_carry];
  assign lt = s ^ v;

  always_comb
  begin
    case (ex_cond)
      alu_pkg::cond_br:   cond_true = 1'b1;
      alu_pkg::cond_bl:   cond_true = lt;
      alu_pkg::cond_bge:  cond_true = !lt;
      alu_pkg::cond_ble:  cond_true = lt || z;
      alu_pkg::cond_bg:   cond_true = !(lt || z);
      alu_pkg::cond_bule: cond_true = !c || z;
      alu_pkg::cond_bug:  cond_true = c && !z;
      alu_pkg::cond_bz:   cond_true = z;
      alu_pkg::cond_bnz:  cond_true = !z;
      alu_pkg::cond_bc:   cond_true = c;
      alu_pkg::cond_bnc:  cond_true = !c;
      alu_pkg::cond_bs:   cond_true = s;
      alu_pkg::cond_bns:  cond_true = !s;
      alu_pkg::cond_bv:   cond_true = v;
      alu_pkg::cond_bnv:  cond_true = !v;
      // Index 15 is never taken
      default:            cond_true = 1'b0;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!rst)
    begin
      result_val <= 1'b0;
      taken_pc   <= 1'b0;
    end
    else
    begin
      result_val <= ex_result_val;
      taken_pc   <= ex_branch && cond_true;
    end
  end

  always_ff @(posedge clk)
  begin
    result  <= ex_result;
    next_pc <= ex_branch ? ex_target : '0;
  end

  // A taken branch came from a branch that left the flags alone
  a_taken_is_branch: assert property (@(posedge clk) disable iff (!rst)
    taken_pc |-> $past(ex_branch && !ex_flag_wr));

endmodule

// ==== verilog/alu_top.sv ====
module alu_top #(
  parameter int DATA_W = 16
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [DATA_W-1:0]         pc,
  input  logic                      op_set_val,
  input  logic                      op_set_hi,
  input  logic                      op_al_val,
  input  logic [2:0]                op_al_code,
  input  logic                      op_shift_val,
  input  logic [3:0]                op_shift_code,
  input  logic                      op_branch_val,
  input  logic [4:0]                op_branch_code,
  input  logic [alu_pkg::IMM_W-1:0] v_data,
  input  logic [DATA_W-1:0]         rf_ra,
  input  logic [DATA_W-1:0]         rf_rb,
  output logic [DATA_W-1:0]         result,
  output logic                      result_val,
  output logic                      taken_pc,
  output logic [DATA_W-1:0]         next_pc
);

  // Issue to execute
  alu_pkg::op_class_t is_class;
  logic [4:0]         is_code;
  logic [DATA_W-1:0]  is_a;
  logic [DATA_W-1:0]  is_b;
  logic [DATA_W-1:0]  is_imm;
  logic [DATA_W-1:0]  is_pc;

  // Execute to retire
  logic [DATA_W-1:0]          ex_result;
  logic                       ex_result_val;
  logic [alu_pkg::FLAG_W-1:0] ex_flags;
  logic                       ex_flag_wr;
  logic                       ex_branch;
  logic [3:0]                 ex_cond;
  logic [DATA_W-1:0]          ex_target;

  // Flag bypass back to execute
  logic [alu_pkg::FLAG_W-1:0] flags_next;

  alu_issue #(
    .DATA_W(DATA_W)
  ) u_issue (
    .clk            (clk),
    .rst            (rst),
    .op_set_val     (op_set_val),
    .op_set_hi      (op_set_hi),
    .op_al_val      (op_al_val),
    .op_al_code     (op_al_code),
    .op_shift_val   (op_shift_val),
    .op_shift_code  (op_shift_code),
    .op_branch_val  (op_branch_val),
    .op_branch_code (op_branch_code),
    .v_data         (v_data),
    .pc             (pc),
    .rf_ra          (rf_ra),
    .rf_rb          (rf_rb),
    .is_class       (is_class),
    .is_code        (is_code),
    .is_a           (is_a),
    .is_b           (is_b),
    .is_imm         (is_imm),
    .is_pc          (is_pc)
  );

  alu_execute #(
    .DATA_W(DATA_W)
  ) u_execute (
    .clk           (clk),
    .rst           (rst),
    .is_class      (is_class),
    .is_code       (is_code),
    .is_a          (is_a),
    .is_b          (is_b),
    .is_imm        (is_imm),
    .is_pc         (is_pc),
    .flags_next    (flags_next),
    .ex_result     (ex_result),
    .ex_result_val (ex_result_val),
    .ex_flags      (ex_flags),
    .ex_flag_wr    (ex_flag_wr),
    .ex_branch     (ex_branch),
    .ex_cond       (ex_cond),
    .ex_target     (ex_target)
  );

  alu_retire #(
    .DATA_W(DATA_W)
  ) u_retire (
    .clk           (clk),
    .rst           (rst),
    .ex_result     (ex_result),
    .ex_result_val (ex_result_val),
    .ex_flags      (ex_flags),
    .ex_flag_wr    (ex_flag_wr),
    .ex_branch     (ex_branch),
    .ex_cond       (ex_cond),
    .ex_target     (ex_target),
    .flags_next    (flags_next),
    .result        (result),
    .result_val    (result_val),
    .taken_pc      (taken_pc),
    .next_pc       (next_pc)
  );

endmodule

// ==== test/alu_tb.sv ====
module alu_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int DATA_W   = 16;
  localparam int FIELDS   = 17;
  localparam int MAX_ROWS = 128;

  // Column positions in a pattern line
  localparam int col_test        = 0;
  localparam int col_set         = 1;
  localparam int col_hi          = 2;
  localparam int col_al          = 3;
  localparam int col_al_code     = 4;
  localparam int col_shift       = 5;
  localparam int col_shift_code  = 6;
  localparam int col_branch      = 7;
  localparam int col_branch_code = 8;
  localparam int col_v_data      = 9;
  localparam int col_pc          = 10;
  localparam int col_ra          = 11;
  localparam int col_rb          = 12;
  localparam int col_rv          = 13;
  localparam int col_result      = 14;
  localparam int col_taken       = 15;
  localparam int col_next_pc     = 16;

  logic              clk = 1'b0;
  logic              rst;
  logic [DATA_W-1:0] pc;
  logic              op_set_val;
  logic              op_set_hi;
  logic              op_al_val;
  logic [2:0]        op_al_code;
  logic              op_shift_val;
  logic [3:0]        op_shift_code;
  logic              op_branch_val;
  logic [4:0]        op_branch_code;
  logic [7:0]        v_data;
  logic [DATA_W-1:0] rf_ra;
  logic [DATA_W-1:0] rf_rb;
  logic [DATA_W-1:0] result;
  logic              result_val;
  logic              taken_pc;
  logic [DATA_W-1:0] next_pc;

  logic [15:0] pat_mem [0:FIELDS*MAX_ROWS-1];
  int n_rows;
  int cycle_count;
  int cycle_limit = MAX_ROWS + 15;
  int error_count;
  int test_errors;
  int tests_run;
  int tests_failed;

  alu_top #(
    .DATA_W(DATA_W)
  ) dut0 (
    .clk            (clk),
    .rst            (rst),
    .pc             (pc),
    .op_set_val     (op_set_val),
    .op_set_hi      (op_set_hi),
    .op_al_val      (op_al_val),
    .op_al_code     (op_al_code),
    .op_shift_val   (op_shift_val),
    .op_shift_code  (op_shift_code),
    .op_branch_val  (op_branch_val),
    .op_branch_code (op_branch_code),
    .v_data         (v_data),
    .rf_ra          (rf_ra),
    .rf_rb          (rf_rb),
    .result         (result),
    .result_val     (result_val),
    .taken_pc       (taken_pc),
    .next_pc        (next_pc)
  );

  always #20 clk = ~clk;

  // Run limit from the pattern count
  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count >= cycle_limit)
    begin
      $display("timeout: outputs did not finish");
      $display("Regression failed");
      $finish;
    end
  end

  function automatic int test_of_row(input int row);
    return int'(pat_mem[row*FIELDS + col_test]);
  endfunction

  task automatic apply_row(input int row);
    logic [15:0] f [0:FIELDS-1];
    for (int i = 0; i < FIELDS; i++)
      f[i] = pat_mem[row*FIELDS + i];
    op_set_val     <= f[col_set][0];
    op_set_hi      <= f[col_hi][0];
    op_al_val      <= f[col_al][0];
    op_al_code     <= f[col_al_code][2:0];
    op_shift_val   <= f[col_shift][0];
    op_shift_code  <= f[col_shift_code][3:0];
    op_branch_val  <= f[col_branch][0];
    op_branch_code <= f[col_branch_code][4:0];
    v_data         <= f[col_v_data][7:0];
    pc             <= f[col_pc];
    rf_ra          <= f[col_ra];
    rf_rb          <= f[col_rb];
  endtask

  task automatic apply_idle();
    op_set_val    <= 1'b0;
    op_al_val     <= 1'b0;
    op_shift_val  <= 1'b0;
    op_branch_val <= 1'b0;
  endtask

  task automatic check_row(input int row);
    logic [15:0] f [0:FIELDS-1];
    int errs;
    errs = 0;
    for (int i = 0; i < FIELDS; i++)
      f[i] = pat_mem[row*FIELDS + i];
    if (result_val !== f[col_rv][0])
    begin
      $display("Error at %0d ns: result_val expected %0h, got %0h",
               $time, f[col_rv][0], result_val);
      errs++;
    end
    // Result only means something while result_val is high
    if (f[col_rv][0] && result !== f[col_result])
    begin
      $display("Error at %0d ns: result expected %04h, got %04h",
               $time, f[col_result], result);
      errs++;
    end
    if (taken_pc !== f[col_taken][0])
    begin
      $display("Error at %0d ns: taken_pc expected %0h, got %0h",
               $time, f[col_taken][0], taken_pc);
      errs++;
    end
    if (next_pc !== f[col_next_pc])
    begin
      $display("Error at %0d ns: next_pc expected %04h, got %04h",
               $time, f[col_next_pc], next_pc);
      errs++;
    end
    error_count += errs;
    test_errors += errs;
  endtask

  task automatic report_test(input int id);
    tests_run++;
    if (test_errors == 0)
      $display("test %0d: ok", id);
    else
    begin
      tests_failed++;
      $display("test %0d: %0d errors", id, test_errors);
    end
    test_errors = 0;
  endtask

  initial
  begin
    rst            = 1'b0;
    pc             = '0;
    op_set_val     = 1'b0;
    op_set_hi      = 1'b0;
    op_al_val      = 1'b0;
    op_al_code     = '0;
    op_shift_val   = 1'b0;
    op_shift_code  = '0;
    op_branch_val  = 1'b0;
    op_branch_code = '0;
    v_data         = '0;
    rf_ra          = '0;
    rf_rb          = '0;
    cycle_count    = 0;
    error_count    = 0;
    test_errors    = 0;
    tests_run      = 0;
    tests_failed   = 0;

    $readmemh("test/alu_patterns.txt", pat_mem);
    n_rows = 0;
    while (n_rows < MAX_ROWS && !$isunknown(pat_mem[n_rows*FIELDS]))
      n_rows++;
    // Reset, pipeline latency and some margin
    cycle_limit = n_rows + 3 + 2 + 10;
    if (n_rows == 0)
    begin
      $display("no pattern lines could be read from test/alu_patterns.txt");
      error_count++;
    end

    repeat (3) @(posedge clk);
    rst <= 1'b1;

    // Outputs of a line show up three edges after it is driven
    for (int t = 0; t < n_rows + 3; t++)
    begin
      @(posedge clk);
      if (t < n_rows)
        apply_row(t);
      else
        apply_idle();
      @(negedge clk);
      if (t >= 3)
      begin
        check_row(t - 3);
        if (t - 3 == n_rows - 1 || test_of_row(t - 2) != test_of_row(t - 3))
          report_test(test_of_row(t - 3));
      end
    end

    $display("Summary: %0d tests run, %0d passed, %0d failed, %0d errors",
             tests_run, tests_run - tests_failed, tests_failed, error_count);
    if (error_count == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

// ==== all.f ====
verilog/alu_pkg.sv
verilog/alu_issue.sv
verilog/alu_execute.sv
verilog/alu_retire.sv
verilog/alu_top.sv
test/alu_tb.sv

// ==== test/alu_patterns.txt ====
// test set hi al alc sh shc br brc vd pc ra rb | result_val result taken_pc next_pc
// All fields hex, one operation per line, one line per clock
1 0 0 0 0 0 0 0 00 00 0000 0000 0000 0 0000 0 0000  // idle after reset
1 0 0 0 0 1 6 0 00 00 0000 0000 0000 1 0000 0 0000  // savef
2 1 0 0 0 0 0 0 00 85 0000 0000 0000 1 ff85 0 0000  // set lo
2 1 1 0 0 0 0 0 00 12 0000 00ab 0000 1 12ab 0 0000  // set hi
2 0 0 0 0 1 6 0 00 00 0000 0000 0000 1 0000 0 0000  // savef
2 0 0 1 0 0 0 0 00 00 0000 f0f0 8f00 1 8000 0 0000  // and
2 0 0 0 0 1 6 0 00 00 0000 0000 0000 1 0001 0 0000  // savef
2 0 0 1 1 0 0 0 00 00 0000 0000 0000 1 0000 0 0000  // or
2 0 0 0 0 1 6 0 00 00 0000 0000 0000 1 0002 0 0000  // savef
2 0 0 1 4 0 0 0 00 00 0000 a5a5 5a5a 1 ffff 0 0000  // xor
2 0 0 0 0 1 6 0 00 00 0000 0000 0000 1 0001 0 0000  // savef
3 0 0 1 2 0 0 0 00 00 0000 ffff 0001 1 0000 0 0000  // add, carry out
3 0 0 1 2 0 0 0 00 00 0000 0001 0001 1 0003 0 0000  // add, carry in
3 0 0 1 2 0 0 0 00 00 0000 7fff 0001 1 8000 0 0000  // add overflow
3 0 0 0 0 1 6 0 00 00 0000 0000 0000 1 0005 0 0000  // savef
3 0 0 1 3 0 0 0 00 00 0000 0005 0003 1 0001 0 0000  // sub, carry in clear
3 0 0 1 3 0 0 0 00 00 0000 0005 0003 1 0002 0 0000  // sub, carry in set
3 0 0 1 3 0 0 0 00 00 0000 0003 0005 1 fffe 0 0000  // sub, borrow
3 0 0 0 0 1 6 0 00 00 0000 0000 0000 1 0001 0 0000  // savef
3 0 0 0 0 1 a 0 00 00 0000 00ff 0000 1 0100 0 0000  // inc
3 0 0 0 0 1 b 0 00 01 0000 0100 0000 1 00fe 0 0000  // dec
3 0 0 0 0 1 a 0 00 ff 0000 ffff 0000 1 00ff 0 0000  // inc ignores carry
3 0 0 0 0 1 b 0 00 00 0000 8000 0000 1 7fff 0 0000  // dec overflow
3 0 0 0 0 1 6 0 00 00 0000 0000 0000 1 000c 0 0000  // savef
4 0 0 0 0 1 0 0 00 00 0000 4001 0000 1 8003 0 0000  // lsl, carry in
4 0 0 0 0 1 0 0 00 00 0000 8000 0000 1 0000 0 0000  // lsl, carry out
4 0 0 0 0 1 1 0 00 00 0000 0002 0000 1 8001 0 0000  // lsr, carry in
4 0 0 0 0 1 4 0 00 00 0000 c000 0000 1 8000 0 0000  // asl
4 0 0 0 0 1 5 0 00 00 0000 8004 0000 1 c002 0 0000  // asr keeps sign
4 0 0 0 0 1 5 0 00 00 0000 0003 0000 1 0001 0 0000  // asr, carry out
4 0 0 0 0 1 2 0 00 00 0000 12ab 0000 1 ab00 0 0000  // lsl8
4 0 0 0 0 1 3 0 00 00 0000 12ab 0000 1 0012 0 0000  // lsr8
4 0 0 0 0 1 1 0 00 00 0000 0000 0000 1 8000 0 0000  // lsr sees old carry
4 0 0 0 0 1 6 0 00 00 0000 0000 0000 1 0004 0 0000  // savef
5 0 0 0 0 1 7 0 00 09 0000 0000 0000 0 0000 0 0000  // setf
5 0 0 0 0 1 6 0 00 00 0000 0000 0000 1 000d 0 0000  // savef
5 0 0 0 0 1 8 0 00 05 0000 0000 0000 0 0000 0 0000  // clrf
5 0 0 0 0 1 6 0 00 00 0000 0000 0000 1 0008 0 0000  // savef
5 0 0 0 0 1 9 0 00 00 0000 0036 0000 0 0000 0 0000  // rstrf
5 0 0 0 0 1 6 0 00 00 0000 0000 0000 1 0006 0 0000  // savef
6 0 0 0 0 1 9 0 00 00 0000 0008 0000 0 0000 0 0000  // rstrf carry only
6 0 0 0 0 0 0 1 00 00 0000 2100 0000 0 0000 1 2100  // br
6 0 0 0 0 0 0 1 02 00 0000 2200 0000 0 0000 0 2200  // bl
6 0 0 0 0 0 0 1 04 00 0000 2300 0000 0 0000 1 2300  // bge
6 0 0 0 0 0 0 1 06 00 0000 2400 0000 0 0000 0 2400  // ble
6 0 0 0 0 0 0 1 08 00 0000 2500 0000 0 0000 1 2500  // bg
6 0 0 0 0 0 0 1 0a 00 0000 2600 0000 0 0000 0 2600  // bule
6 0 0 0 0 0 0 1 0c 00 0000 2700 0000 0 0000 1 2700  // bug
6 0 0 0 0 0 0 1 0e 00 0000 2800 0000 0 0000 0 2800  // bz
6 0 0 0 0 0 0 1 10 00 0000 2900 0000 0 0000 1 2900  // bnz
6 0 0 0 0 0 0 1 12 00 0000 2a00 0000 0 0000 1 2a00  // bc
6 0 0 0 0 0 0 1 14 00 0000 2b00 0000 0 0000 0 2b00  // bnc
6 0 0 0 0 0 0 1 16 00 0000 2c00 0000 0 0000 0 2c00  // bs
6 0 0 0 0 0 0 1 18 00 0000 2d00 0000 0 0000 1 2d00  // bns
6 0 0 0 0 0 0 1 1a 00 0000 2e00 0000 0 0000 0 2e00  // bv
6 0 0 0 0 0 0 1 1c 00 0000 2f00 0000 0 0000 1 2f00  // bnv
7 0 0 0 0 1 9 0 00 00 0000 0006 0000 0 0000 0 0000  // rstrf zero and overflow
7 0 0 0 0 0 0 1 01 10 0400 0000 0000 0 0000 1 0410  // br
7 0 0 0 0 0 0 1 03 f0 0400 0000 0000 0 0000 1 03f0  // bl
7 0 0 0 0 0 0 1 05 7f 0400 0000 0000 0 0000 0 047f  // bge
7 0 0 0 0 0 0 1 07 80 0400 0000 0000 0 0000 1 0380  // ble
7 0 0 0 0 0 0 1 09 01 0400 0000 0000 0 0000 0 0401  // bg
7 0 0 0 0 0 0 1 0b ff 0400 0000 0000 0 0000 1 03ff  // bule
7 0 0 0 0 0 0 1 0d 20 0400 0000 0000 0 0000 0 0420  // bug
7 0 0 0 0 0 0 1 0f e0 0400 0000 0000 0 0000 1 03e0  // bz
7 0 0 0 0 0 0 1 11 30 0400 0000 0000 0 0000 0 0430  // bnz
7 0 0 0 0 0 0 1 13 d0 0400 0000 0000 0 0000 0 03d0  // bc
7 0 0 0 0 0 0 1 15 40 0400 0000 0000 0 0000 1 0440  // bnc
7 0 0 0 0 0 0 1 17 c0 0400 0000 0000 0 0000 0 03c0  // bs
7 0 0 0 0 0 0 1 19 50 0400 0000 0000 0 0000 1 0450  // bns
7 0 0 0 0 0 0 1 1b b0 0400 0000 0000 0 0000 1 03b0  // bv
7 0 0 0 0 0 0 1 1d 60 0400 0000 0000 0 0000 0 0460  // bnv
8 0 0 0 0 1 9 0 00 00 0000 0001 0000 0 0000 0 0000  // rstrf sign only
8 0 0 0 0 0 0 1 17 08 0500 0000 0000 0 0000 1 0508  // bs relative
8 0 0 0 0 0 0 1 18 00 0000 3300 0000 0 0000 0 3300  // bns
8 0 0 0 0 0 0 1 02 00 0000 3400 0000 0 0000 1 3400  // bl
8 0 0 0 0 0 0 1 05 fc 0500 0000 0000 0 0000 0 04fc  // bge relative
8 0 0 0 0 0 0 1 1e 00 0000 3500 0000 0 0000 0 3500  // code 30
8 0 0 0 0 0 0 1 1f 10 0500 0000 0000 0 0000 0 0510  // code 31
